// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tbAxiSubsystem
FILELIST  ?= project.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: dv/tbAxiSubsystem.sv
`timescale 1ns/100ps

module tbAxiSubsystem;
  import axiPkg::*;

  localparam int WaitLimit  = 100;
  localparam int NumEntries = 13;

  typedef struct packed {
    logic        isRead;
    logic [3:0]  id;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [1:0]  resp;
  } StimEntry;

  logic clk;
  logic rst;
  logic [3:0] awId, arId, bId, rId;
  logic [31:0] awAddr, arAddr, wData, rData;
  logic [3:0] wStrb;
  logic [1:0] bResp, rResp;
  logic awValid, awReady, wValid, wReady, bValid, bReady;
  logic arValid, arReady, rValid, rReady, rLast;

  StimEntry    stim [NumEntries];
  logic [31:0] model [1024];
  logic        written [1024];
  logic [31:0] lfsrState;

  axiSubsystem u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic expectEqual(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Columns are isRead, id, addr, data, strb and the expected response
  task automatic fillTable();
    stim[0]  = '{1'b0, 4'h1, 32'h0000_0010, 32'hA5A5_1234, 4'hF, RespOkay};
    stim[1]  = '{1'b0, 4'h2, 32'h0000_0010, 32'h5A00_00CC, 4'h5, RespOkay};
    stim[2]  = '{1'b1, 4'h3, 32'h0000_0010, 32'h0, 4'h0, RespOkay};
    stim[3]  = '{1'b0, 4'h4, 32'h0000_0FFC, 32'hDEAD_BEEF, 4'hF, RespOkay};
    stim[4]  = '{1'b1, 4'h5, 32'h0000_1000, 32'h0, 4'h0, RespDecErr};
    stim[5]  = '{1'b0, 4'h6, 32'h8000_0000, 32'h1111_2222, 4'hF, RespDecErr};
    stim[6]  = '{1'b1, 4'h7, 32'h0000_0FFC, 32'h0, 4'h0, RespOkay};
    stim[7]  = '{1'b0, 4'h8, 32'h0000_0200, 32'hCAFE_F00D, 4'hF, RespOkay};
    stim[8]  = '{1'b0, 4'h9, 32'h0000_0200, 32'h0000_7700, 4'h2, RespOkay};
    stim[9]  = '{1'b1, 4'hA, 32'hFFFF_FFFC, 32'h0, 4'h0, RespDecErr};
    stim[10] = '{1'b0, 4'hB, 32'h0000_1004, 32'h3333_4444, 4'h3, RespDecErr};
    stim[11] = '{1'b1, 4'hC, 32'h0000_0200, 32'h0, 4'h0, RespOkay};
    stim[12] = '{1'b1, 4'hF, 32'h0000_4000, 32'h0, 4'h0, RespDecErr};
  endtask

  // ----------------------------------------
  // Write where order 0 sends AW first, 1 sends W first and else both together
  // ----------------------------------------
  task automatic writeTxn(input StimEntry e, input logic [1:0] order);
    logic awDone, wDone, awHit, wHit, done, seen;
    int   cnt;
    awDone = 1'b0;
    wDone  = 1'b0;
    cnt    = 0;
    @(posedge clk);
    awId    <= e.id;
    awAddr  <= e.addr;
    wData   <= e.data;
    wStrb   <= e.strb;
    awValid <= (order != 2'd1);
    wValid  <= (order != 2'd0);
    while (!(awDone && wDone)) begin
      @(negedge clk);
      awHit = awValid && awReady;
      wHit  = wValid && wReady;
      // W has no target until an address shows up
      if (!awValid && !awDone) expectEqual("wReady", 32'(wReady), 32'd0);
      cnt++;
      if (cnt > WaitLimit) failRun("Timeout waiting for the AW and W handshakes");
      @(posedge clk);
      if (awHit) begin
        awValid <= 1'b0;
        awDone = 1'b1;
      end
      if (wHit) begin
        wValid <= 1'b0;
        wDone = 1'b1;
      end
      if (order == 2'd0 && awDone && !wDone) wValid <= 1'b1;
      if (order == 2'd1 && !awDone) awValid <= 1'b1;
    end
    bReady <= lfsrBit();
    done = 1'b0;
    seen = 1'b0;
    cnt  = 0;
    while (!done) begin
      @(negedge clk);
      cnt++;
      if (cnt > WaitLimit) failRun("Timeout waiting for the write response");
      if (seen) expectEqual("bValid", 32'(bValid), 32'd1);
      expectEqual("awReady", 32'(awReady), 32'd0);
      if (bValid) begin
        seen = 1'b1;
        expectEqual("bId", 32'(bId), 32'(e.id));
        expectEqual("bResp", 32'(bResp), 32'(e.resp));
        done = bReady;
      end
      @(posedge clk);
      bReady <= done ? 1'b0 : lfsrBit();
    end
  endtask

  // ----------------------------------------
  // Each read is issued twice back to back so the repeat waits on the open one
  // ----------------------------------------
  task automatic readTxn(input logic [3:0] id, input logic [31:0] addr,
                         input logic [31:0] expData, input logic [1:0] expResp);
    logic hit, done, seen;
    int   rep, cnt;
    @(posedge clk);
    arId    <= id;
    arAddr  <= addr;
    arValid <= 1'b1;
    for (rep = 0; rep < 2; rep++) begin
      hit = 1'b0;
      cnt = 0;
      while (!hit) begin
        @(negedge clk);
        hit = arValid && arReady;
        cnt++;
        if (cnt > WaitLimit) failRun("Timeout waiting for the AR handshake");
        @(posedge clk);
      end
      arValid <= (rep == 0);
      rReady  <= lfsrBit();
      done = 1'b0;
      seen = 1'b0;
      cnt  = 0;
      while (!done) begin
        @(negedge clk);
        cnt++;
        if (cnt > WaitLimit) failRun("Timeout waiting for the read response");
        if (seen) expectEqual("rValid", 32'(rValid), 32'd1);
        expectEqual("arReady", 32'(arReady), 32'd0);
        if (rValid) begin
          seen = 1'b1;
          expectEqual("rId", 32'(rId), 32'(id));
          expectEqual("rData", rData, expData);
          expectEqual("rResp", 32'(rResp), 32'(expResp));
          expectEqual("rLast", 32'(rLast), 32'd1);
          done = rReady;
        end
        @(posedge clk);
        rReady <= done ? 1'b0 : lfsrBit();
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int          n;
    int          nWrites;
    logic [1:0]  order;
    logic [31:0] expData;
    logic [9:0]  idx;
    lfsrState = 32'h61be;
    rst     = 1'b0;
    awId    = '0;
    awAddr  = '0;
    awValid = 1'b0;
    wData   = '0;
    wStrb   = '0;
    wValid  = 1'b0;
    bReady  = 1'b0;
    arId    = '0;
    arAddr  = '0;
    arValid = 1'b0;
    rReady  = 1'b0;
    nWrites = 0;
    for (int i = 0; i < 1024; i++) written[i] = 1'b0;
    fillTable();
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    expectEqual("rValid", 32'(rValid), 32'd0);
    expectEqual("bValid", 32'(bValid), 32'd0);

    for (n = 0; n < NumEntries; n++) begin
      idx = stim[n].addr[11:2];
      if (stim[n].isRead) begin
        expData = (stim[n].resp == RespOkay) ? model[idx] : 32'd0;
        readTxn(stim[n].id, stim[n].addr, expData, stim[n].resp);
      end else begin
        // First three writes cover each AW/W ordering once
        order = (nWrites < 3) ? 2'(nWrites) : {lfsrBit(), lfsrBit()};
        nWrites++;
        writeTxn(stim[n], order);
        if (stim[n].resp == RespOkay) begin
          if (!written[idx]) model[idx] = 32'd0;
          for (int b = 0; b < 4; b++) begin
            if (stim[n].strb[b]) model[idx][8*b +: 8] = stim[n].data[8*b +: 8];
          end
          written[idx] = 1'b1;
        end
      end
    end

    // Every SRAM word written must survive the unmapped accesses
    for (int i = 0; i < 1024; i++) begin
      if (written[i]) readTxn(4'(i), 32'(i * 4), model[i], RespOkay);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: project.f
verilog/axiPkg.sv
verilog/axiBus.sv
verilog/addrDecoder.sv
verilog/defaultSlave.sv
verilog/sramSlave.sv
verilog/axiSubsystem.sv
dv/tbAxiSubsystem.sv

// File: verilog/addrDecoder.sv
`timescale 1ns/100ps

module addrDecoder (
  input  logic  clk,
  input  logic  rst,
  axiBus.slave  up,
  axiBus.master sram,
  axiBus.master dflt
);
  import axiPkg::*;

  SlaveSel arSel;
  SlaveSel awSel;
  SlaveSel wSel;
  SlaveSel rdSel;
  SlaveSel wrSel;
  logic    rdBusy;
  logic    wrBusy;
  logic    wGate;
  logic    arHs;
  logic    rHs;
  logic    awHs;
  logic    bHs;

  // ----------------------------------------
  // Read direction
  // ----------------------------------------
  assign arSel = decodeAddr(up.arAddr);
  assign arHs  = up.arValid & up.arReady;
  assign rHs   = up.rValid & up.rReady;

  assign sram.arId    = up.arId;
  assign sram.arAddr  = up.arAddr;
  assign dflt.arId    = up.arId;
  assign dflt.arAddr  = up.arAddr;
  assign sram.arValid = up.arValid & ~rdBusy & (arSel == SelSram);
  assign dflt.arValid = up.arValid & ~rdBusy & (arSel == SelDefault);
  assign up.arReady   = ~rdBusy & ((arSel == SelSram) ? sram.arReady : dflt.arReady);

  // Response comes back from the remembered target
  assign up.rId    = (rdSel == SelSram) ? sram.rId : dflt.rId;
  assign up.rData  = (rdSel == SelSram) ? sram.rData : dflt.rData;
  assign up.rResp  = (rdSel == SelSram) ? sram.rResp : dflt.rResp;
  assign up.rLast  = (rdSel == SelSram) ? sram.rLast : dflt.rLast;
  assign up.rValid = rdBusy & ((rdSel == SelSram) ? sram.rValid : dflt.rValid);

  assign sram.rReady = rdBusy & (rdSel == SelSram) & up.rReady;
  assign dflt.rReady = rdBusy & (rdSel == SelDefault) & up.rReady;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rdBusy <= 1'b0;
      rdSel  <= SelDefault;
    end else if (arHs) begin
      rdBusy <= 1'b1;
      rdSel  <= arSel;
    end else if (rHs) begin
      rdBusy <= 1'b0;
    end
  end

  // ----------------------------------------
  // Write direction
  // ----------------------------------------
  assign awSel = decodeAddr(up.awAddr);
  assign awHs  = up.awValid & up.awReady;
  assign bHs   = up.bValid & up.bReady;

  assign sram.awId    = up.awId;
  assign sram.awAddr  = up.awAddr;
  assign dflt.awId    = up.awId;
  assign dflt.awAddr  = up.awAddr;
  assign sram.awValid = up.awValid & ~wrBusy & (awSel == SelSram);
  assign dflt.awValid = up.awValid & ~wrBusy & (awSel == SelDefault);
  assign up.awReady   = ~wrBusy & ((awSel == SelSram) ? sram.awReady : dflt.awReady);

  // W needs a known target: a valid AW address or the one already taken
  assign wGate = wrBusy | up.awValid;
  assign wSel  = wrBusy ? wrSel : awSel;

  assign sram.wData  = up.wData;
  assign sram.wStrb  = up.wStrb;
  assign dflt.wData  = up.wData;
  assign dflt.wStrb  = up.wStrb;
  assign sram.wValid = up.wValid & wGate & (wSel == SelSram);
  assign dflt.wValid = up.wValid & wGate & (wSel == SelDefault);
  assign up.wReady   = wGate & ((wSel == SelSram) ? sram.wReady : dflt.wReady);

  assign up.bId    = (wrSel == SelSram) ? sram.bId : dflt.bId;
  assign up.bResp  = (wrSel == SelSram) ? sram.bResp : dflt.bResp;
  assign up.bValid = wrBusy & ((wrSel == SelSram) ? sram.bValid : dflt.bValid);

  assign sram.bReady = wrBusy & (wrSel == SelSram) & up.bReady;
  assign dflt.bReady = wrBusy & (wrSel == SelDefault) & up.bReady;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wrBusy <= 1'b0;
      wrSel  <= SelDefault;
    end else if (awHs) begin
      wrBusy <= 1'b1;
      wrSel  <= awSel;
    end else if (bHs) begin
      wrBusy <= 1'b0;
    end
  end

endmodule

// File: verilog/axiBus.sv
`timescale 1ns/100ps

interface axiBus;
  import axiPkg::*;

  // Write address
  logic [AxiIdBits-1:0]   awId;
  logic [AxiAddrBits-1:0] awAddr;
  logic                   awValid;
  logic                   awReady;

  // Write data
  logic [AxiDataBits-1:0] wData;
  logic [AxiStrbBits-1:0] wStrb;
  logic                   wValid;
  logic                   wReady;

  // Write response
  logic [AxiIdBits-1:0]   bId;
  logic [1:0]             bResp;
  logic                   bValid;
  logic                   bReady;

  // Read address
  logic [AxiIdBits-1:0]   arId;
  logic [AxiAddrBits-1:0] arAddr;
  logic                   arValid;
  logic                   arReady;

  // Read data, single beat
  logic [AxiIdBits-1:0]   rId;
  logic [AxiDataBits-1:0] rData;
  logic [1:0]             rResp;
  logic                   rLast;
  logic                   rValid;
  logic                   rReady;

  modport master (
    output awId, awAddr, awValid, wData, wStrb, wValid, bReady,
    output arId, arAddr, arValid, rReady,
    input  awReady, wReady, bId, bResp, bValid,
    input  arReady, rId, rData, rResp, rLast, rValid
  );

  modport slave (
    input  awId, awAddr, awValid, wData, wStrb, wValid, bReady,
    input  arId, arAddr, arValid, rReady,
    output awReady, wReady, bId, bResp, bValid,
    output arReady, rId, rData, rResp, rLast, rValid
  );

endinterface

// File: verilog/axiPkg.sv
package axiPkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int AxiIdBits   = 4;
  localparam int AxiAddrBits = 32;
  localparam int AxiDataBits = 32;
  localparam int AxiStrbBits = AxiDataBits / 8;

  // Response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespDecErr = 2'b11;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam logic [AxiAddrBits-1:0] SramBase = 32'h0000_0000;
  localparam int SramWords    = 1024;
  localparam int SramAddrBits = $clog2(SramWords);
  localparam logic [AxiAddrBits-1:0] SramBytes = AxiAddrBits'(SramWords * AxiStrbBits);

  typedef enum logic {
    SelSram    = 1'b0,
    SelDefault = 1'b1
  } SlaveSel;

  // Addresses below the base wrap to a large offset and fall out of range
  function automatic SlaveSel decodeAddr(input logic [AxiAddrBits-1:0] addr);
    logic [AxiAddrBits-1:0] offset;
    offset = addr - SramBase;
    return (offset < SramBytes) ? SelSram : SelDefault;
  endfunction

  // Word index inside the SRAM region
  function automatic logic [SramAddrBits-1:0] sramIndex(input logic [AxiAddrBits-1:0] addr);
    logic [AxiAddrBits-1:0] offset;
    offset = addr - SramBase;
    return offset[SramAddrBits+1:2];
  endfunction

endpackage

// File: verilog/axiSubsystem.sv
`timescale 1ns/100ps

module axiSubsystem (
  input  logic                           clk,
  input  logic                           rst,

  input  logic [axiPkg::AxiIdBits-1:0]   awId,
  input  logic [axiPkg::AxiAddrBits-1:0] awAddr,
  input  logic                           awValid,
  output logic                           awReady,

  input  logic [axiPkg::AxiDataBits-1:0] wData,
  input  logic [axiPkg::AxiStrbBits-1:0] wStrb,
  input  logic                           wValid,
  output logic                           wReady,

  output logic [axiPkg::AxiIdBits-1:0]   bId,
  output logic [1:0]                     bResp,
  output logic                           bValid,
  input  logic                           bReady,

  input  logic [axiPkg::AxiIdBits-1:0]   arId,
  input  logic [axiPkg::AxiAddrBits-1:0] arAddr,
  input  logic                           arValid,
  output logic                           arReady,

  output logic [axiPkg::AxiIdBits-1:0]   rId,
  output logic [axiPkg::AxiDataBits-1:0] rData,
  output logic [1:0]                     rResp,
  output logic                           rLast,
  output logic                           rValid,
  input  logic                           rReady
);

  axiBus busIn ();
  axiBus busSram ();
  axiBus busDflt ();

  // Master side of the fabric
  assign busIn.awId    = awId;
  assign busIn.awAddr  = awAddr;
  assign busIn.awValid = awValid;
  assign busIn.wData   = wData;
  assign busIn.wStrb   = wStrb;
  assign busIn.wValid  = wValid;
  assign busIn.bReady  = bReady;
  assign busIn.arId    = arId;
  assign busIn.arAddr  = arAddr;
  assign busIn.arValid = arValid;
  assign busIn.rReady  = rReady;

  assign awReady = busIn.awReady;
  assign wReady  = busIn.wReady;
  assign bId     = busIn.bId;
  assign bResp   = busIn.bResp;
  assign bValid  = busIn.bValid;
  assign arReady = busIn.arReady;
  assign rId     = busIn.rId;
  assign rData   = busIn.rData;
  assign rResp   = busIn.rResp;
  assign rLast   = busIn.rLast;
  assign rValid  = busIn.rValid;

  addrDecoder u_decoder (
    .clk  (clk),
    .rst  (rst),
    .up   (busIn.slave),
    .sram (busSram.master),
    .dflt (busDflt.master)
  );

  sramSlave u_sram (
    .clk (clk),
    .rst (rst),
    .bus (busSram.slave)
  );

  defaultSlave u_dflt (
    .clk (clk),
    .rst (rst),
    .bus (busDflt.slave)
  );

endmodule

// File: verilog/defaultSlave.sv
`timescale 1ns/100ps

module defaultSlave (
  input  logic clk,
  input  logic rst,
  axiBus.slave bus
);
  import axiPkg::*;

  logic arHs;
  logic rHs;
  logic awHs;
  logic wHs;
  logic bHs;
  logic awLock;
  logic wLock;
  logic awDone;
  logic wDone;

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  assign arHs = bus.arValid & bus.arReady;
  assign rHs  = bus.rValid & bus.rReady;

  // No new address while a response waits
  assign bus.arReady = ~bus.rValid;
  assign bus.rData   = '0;
  assign bus.rResp   = RespDecErr;
  assign bus.rLast   = 1'b1;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      bus.rValid <= 1'b0;
    end else if (arHs) begin
      bus.rValid <= 1'b1;
    end else if (rHs) begin
      bus.rValid <= 1'b0;
    end
  end

  // ----------------------------------------
  // Write channel
  // ----------------------------------------
  assign awHs   = bus.awValid & bus.awReady;
  assign wHs    = bus.wValid & bus.wReady;
  assign bHs    = bus.bValid & bus.bReady;
  assign awDone = awHs | awLock;
  assign wDone  = wHs | wLock;

  assign bus.awReady = ~awLock;
  assign bus.wReady  = ~wLock;
  assign bus.bResp   = RespDecErr;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      awLock     <= 1'b0;
      wLock      <= 1'b0;
      bus.bValid <= 1'b0;
    end else if (bHs) begin
      awLock     <= 1'b0;
      wLock      <= 1'b0;
      bus.bValid <= 1'b0;
    end else begin
      if (awHs) awLock <= 1'b1;
      if (wHs) wLock <= 1'b1;
      if (awDone & wDone) bus.bValid <= 1'b1;
    end
  end

  // Response IDs echo the request
  always_ff @(posedge clk) begin
    if (arHs) bus.rId <= bus.arId;
    if (awHs) bus.bId <= bus.awId;
  end

endmodule

// File: verilog/sramSlave.sv
`timescale 1ns/100ps

module sramSlave (
  input  logic clk,
  input  logic rst,
  axiBus.slave bus
);
  import axiPkg::*;

  logic [AxiDataBits-1:0]  mem [SramWords];
  logic [SramAddrBits-1:0] awIdxReg;
  logic [AxiDataBits-1:0]  wDataReg;
  logic [AxiStrbBits-1:0]  wStrbReg;
  logic [SramAddrBits-1:0] wrIdx;
  logic [AxiDataBits-1:0]  wrData;
  logic [AxiStrbBits-1:0]  wrStrb;
  logic arHs;
  logic rHs;
  logic awHs;
  logic wHs;
  logic bHs;
  logic awLock;
  logic wLock;
  logic wrFire;

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  assign arHs = bus.arValid & bus.arReady;
  assign rHs  = bus.rValid & bus.rReady;

  assign bus.arReady = ~bus.rValid;
  assign bus.rResp   = RespOkay;
  assign bus.rLast   = 1'b1;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      bus.rValid <= 1'b0;
    end else if (arHs) begin
      bus.rValid <= 1'b1;
    end else if (rHs) begin
      bus.rValid <= 1'b0;
    end
  end

  // ----------------------------------------
  // Write channel
  // ----------------------------------------
  assign awHs = bus.awValid & bus.awReady;
  assign wHs  = bus.wValid & bus.wReady;
  assign bHs  = bus.bValid & bus.bReady;

  assign bus.awReady = ~awLock;
  assign bus.wReady  = ~wLock;
  assign bus.bResp   = RespOkay;

  // Fires once, on the edge that completes the later of AW and W
  assign wrFire = (awHs | awLock) & (wHs | wLock) & ~bus.bValid;
  assign wrIdx  = awHs ? sramIndex(bus.awAddr) : awIdxReg;
  assign wrData = wHs ? bus.wData : wDataReg;
  assign wrStrb = wHs ? bus.wStrb : wStrbReg;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      awLock     <= 1'b0;
      wLock      <= 1'b0;
      bus.bValid <= 1'b0;
    end else if (bHs) begin
      awLock     <= 1'b0;
      wLock      <= 1'b0;
      bus.bValid <= 1'b0;
    end else begin
      if (awHs) awLock <= 1'b1;
      if (wHs) wLock <= 1'b1;
      if (wrFire) bus.bValid <= 1'b1;
    end
  end

  // Storage and captured request fields
  always_ff @(posedge clk) begin
    if (arHs) begin
      bus.rId   <= bus.arId;
      bus.rData <= mem[sramIndex(bus.arAddr)];
    end
    if (awHs) begin
      bus.bId  <= bus.awId;
      awIdxReg <= sramIndex(bus.awAddr);
    end
    if (wHs) begin
      wDataReg <= bus.wData;
      wStrbReg <= bus.wStrb;
    end
    if (wrFire) begin
      for (int i = 0; i < AxiStrbBits; i++) begin
        if (wrStrb[i]) mem[wrIdx][8*i +: 8] <= wrData[8*i +: 8];
      end
    end
  end

endmodule
